//--- ext_cmd_queue.sv
// Command FIFO holding external read requests until an ID and the AR channel are free

`timescale 1ns/1ps

module ext_cmd_queue #(
   parameter int unsigned DEPTH = 4
) (
   input  logic                     clk_i,
   input  logic                     rst_ni,
   input  mchan_rx_pkg::ext_add_t   push_add_i,
   input  mchan_rx_pkg::mchan_len_t push_len_i,
   input  logic                     push_bst_i,
   input  logic                     push_req_i,
   output logic                     push_gnt_o,
   output logic                     pop_req_o,
   input  logic                     pop_gnt_i,
   output mchan_rx_pkg::ext_add_t   pop_add_o,
   output mchan_rx_pkg::mchan_len_t pop_len_o,
   output logic                     pop_bst_o
);
   import mchan_rx_pkg::*;

   localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int unsigned CNT_W = $clog2(DEPTH + 1);

   ext_add_t   add_mem [DEPTH];   // Command storage, no reset
   mchan_len_t len_mem [DEPTH];
   logic       bst_mem [DEPTH];

   logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
   logic [CNT_W-1:0] cnt_q;       // Occupancy
   logic             push, pop;

   // Wrap for depths that are not a power of two
   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign push_gnt_o = (cnt_q != CNT_W'(DEPTH)); // Room left
   assign pop_req_o  = (cnt_q != '0);            // Level request while not empty
   assign push       = push_req_i & push_gnt_o;
   assign pop        = pop_gnt_i & pop_req_o;

   always_ff @(posedge clk_i, negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         cnt_q    <= '0;
      end
      else
      begin
         if (push) wr_ptr_q <= ptr_inc(wr_ptr_q);
         if (pop)  rd_ptr_q <= ptr_inc(rd_ptr_q);
         if (push && !pop)
            cnt_q <= cnt_q + 1'b1;
         else if (pop && !push)
            cnt_q <= cnt_q - 1'b1;
      end
   end

   // Payload write
   always_ff @(posedge clk_i)
   begin
      if (push)
      begin
         add_mem[wr_ptr_q] <= push_add_i;
         len_mem[wr_ptr_q] <= push_len_i;
         bst_mem[wr_ptr_q] <= push_bst_i;
      end
   end

   // Head of queue straight to the interface
   assign pop_add_o = add_mem[rd_ptr_q];
   assign pop_len_o = len_mem[rd_ptr_q];
   assign pop_bst_o = bst_mem[rd_ptr_q];

endmodule

//--- ext_rx_data_buffer.sv
// Beat FIFO, transaction FIFO and TCDM write sequencer with word address counter

`timescale 1ns/1ps

module ext_rx_data_buffer #(
   parameter int unsigned NB_TID = 4
) (
   input  logic                    clk_i,
   input  logic                    rst_ni,
   input  logic                    trans_rx_req_i,
   input  mchan_rx_pkg::ext_tid_t  trans_tid_i,
   output logic                    trans_rx_gnt_o,
   input  logic                    rx_data_req_i,
   input  mchan_rx_pkg::axi_data_t rx_data_dat_i,
   input  logic                    rx_data_last_i,
   output logic                    rx_data_gnt_o,
   output mchan_rx_pkg::ext_tid_t  look_tid_o,
   input  mchan_rx_pkg::ext_add_t  look_add_i,
   output logic                    tcdm_req_o,
   output mchan_rx_pkg::tcdm_add_t tcdm_add_o,
   output mchan_rx_pkg::axi_data_t tcdm_data_o,
   input  logic                    tcdm_gnt_i
);
   import mchan_rx_pkg::*;

   localparam int unsigned BYTE_W = $clog2(BEAT_BYTES);
   localparam int unsigned PTR_W  = (NB_TID > 1) ? $clog2(NB_TID) : 1;
   localparam int unsigned CNT_W  = $clog2(NB_TID + 1);

   tcdm_add_t        base_mem [NB_TID];  // Word base of each open transaction
   axi_data_t        dat_mem  [NB_TID];  // Beat payload
   logic             last_mem [NB_TID];
   logic [PTR_W-1:0] t_wr_q, t_rd_q, b_wr_q, b_rd_q;
   logic [CNT_W-1:0] t_cnt_q, b_cnt_q;
   logic             t_push, t_pop, b_push, b_pop, wr_done;
   logic             cnt_valid_q;        // Counter holds the next address
   tcdm_add_t        word_cnt_q;

   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(NB_TID - 1)) ? '0 : ptr + 1'b1;
   endfunction

   // Base lookup while the ID is still held by this burst
   assign look_tid_o     = trans_tid_i;

   assign trans_rx_gnt_o = (t_cnt_q != CNT_W'(NB_TID));
   assign rx_data_gnt_o  = (b_cnt_q != CNT_W'(NB_TID));
   assign t_push         = trans_rx_req_i & trans_rx_gnt_o;
   assign b_push         = rx_data_req_i & rx_data_gnt_o;

   //**************************************************
   // TCDM write side
   //**************************************************
   assign tcdm_req_o  = (t_cnt_q != '0) && (b_cnt_q != '0);
   assign tcdm_add_o  = cnt_valid_q ? word_cnt_q : base_mem[t_rd_q]; // First beat from base
   assign tcdm_data_o = dat_mem[b_rd_q];
   assign wr_done     = tcdm_req_o & tcdm_gnt_i;
   assign b_pop       = wr_done;
   assign t_pop       = wr_done & last_mem[b_rd_q]; // Transaction closes on last beat

   always_ff @(posedge clk_i, negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         t_wr_q      <= '0;
         t_rd_q      <= '0;
         t_cnt_q     <= '0;
         b_wr_q      <= '0;
         b_rd_q      <= '0;
         b_cnt_q     <= '0;
         cnt_valid_q <= 1'b0;
      end
      else
      begin
         if (t_push) t_wr_q <= ptr_inc(t_wr_q);
         if (t_pop)  t_rd_q <= ptr_inc(t_rd_q);
         if (b_push) b_wr_q <= ptr_inc(b_wr_q);
         if (b_pop)  b_rd_q <= ptr_inc(b_rd_q);
         t_cnt_q <= t_cnt_q + CNT_W'(t_push) - CNT_W'(t_pop);
         b_cnt_q <= b_cnt_q + CNT_W'(b_push) - CNT_W'(b_pop);
         if (wr_done)
            cnt_valid_q <= !last_mem[b_rd_q];   // Reload from base on next transaction
      end
   end

   // Storage and word counter
   always_ff @(posedge clk_i)
   begin
      if (t_push) base_mem[t_wr_q] <= tcdm_add_t'(look_add_i >> BYTE_W);
      if (b_push)
      begin
         dat_mem[b_wr_q]  <= rx_data_dat_i;
         last_mem[b_wr_q] <= rx_data_last_i;
      end
      if (wr_done) word_cnt_q <= tcdm_add_o + 1'b1; // Next word of the burst
   end

endmodule

//--- ext_rx_if.sv
// AR request decode, beat count and R channel tracking FSM

`timescale 1ns/1ps

module ext_rx_if (
   input  logic                     clk_i,
   input  logic                     rst_ni,
   // Command from the queue
   input  mchan_rx_pkg::ext_add_t   cmd_add_i,
   input  mchan_rx_pkg::mchan_len_t cmd_len_i,
   input  logic                     cmd_bst_i,
   input  logic                     cmd_req_i,
   output logic                     cmd_gnt_o,
   // ID generator
   input  logic                     valid_tid_i,
   input  mchan_rx_pkg::ext_tid_t   new_tid_i,
   output logic                     release_tid_o,
   output mchan_rx_pkg::ext_tid_t   res_tid_o,
   // AXI AR
   output logic                     axi_ar_valid_o,
   output mchan_rx_pkg::axi_addr_t  axi_ar_addr_o,
   output mchan_rx_pkg::axi_len_t   axi_ar_len_o,
   output logic [2:0]               axi_ar_size_o,
   output logic [1:0]               axi_ar_burst_o,
   output mchan_rx_pkg::axi_id_t    axi_ar_id_o,
   input  logic                     axi_ar_ready_i,
   // AXI R
   input  logic                     axi_r_valid_i,
   input  logic                     axi_r_last_i,
   input  mchan_rx_pkg::axi_id_t    axi_r_id_i,
   output logic                     axi_r_ready_o,
   // Data buffer
   input  logic                     trans_rx_gnt_i,
   input  logic                     tcdm_gnt_i,
   input  logic                     rx_data_gnt_i,
   output logic                     trans_rx_req_o,
   output logic                     rx_data_req_o,
   output logic                     synch_req_o
);
   import mchan_rx_pkg::*;

   localparam int unsigned BYTE_W = $clog2(BEAT_BYTES); // Byte offset bits

   typedef enum logic {trans_idle, trans_run} state_t;

   state_t           state_q, state_d;
   mchan_len_t       beats_base;   // Whole words in the length
   logic [BYTE_W:0]  low_sum;      // Carry into bit BYTE_W means one more beat
   axi_len_t         beats_nb;
   logic             start_ok;     // Buffer can open a new transaction
   logic             accept;       // Beat taken this cycle

   //**************************************************
   // Beat count
   //**************************************************
   always_comb
   begin
      beats_base = cmd_len_i >> BYTE_W;
      low_sum    = {1'b0, cmd_add_i[BYTE_W-1:0]} + {1'b0, cmd_len_i[BYTE_W-1:0]};
      if (low_sum[BYTE_W])
         beats_nb = axi_len_t'(beats_base + mchan_len_t'(1)); // Crosses a word boundary
      else
         beats_nb = axi_len_t'(beats_base);
   end

   //**************************************************
   // Request channel
   //**************************************************
   // Queue head, AR slot and free ID all needed in the same cycle
   assign cmd_gnt_o      = cmd_req_i & axi_ar_ready_i & valid_tid_i;
   assign axi_ar_valid_o = cmd_gnt_o;

   assign axi_ar_addr_o  = axi_addr_t'(cmd_add_i);   // Zero-extended
   assign axi_ar_len_o   = beats_nb;
   assign axi_ar_size_o  = 3'(BYTE_W);               // 8 bytes per beat
   assign axi_ar_burst_o = cmd_bst_i ? BURST_INCR : BURST_FIXED;
   assign axi_ar_id_o    = axi_id_t'(new_tid_i);

   //**************************************************
   // Response channel FSM
   //**************************************************
   always_ff @(posedge clk_i, negedge rst_ni)
   begin
      if (!rst_ni)
         state_q <= trans_idle;
      else
         state_q <= state_d;
   end

   assign start_ok = trans_rx_gnt_i & tcdm_gnt_i; // TCDM grant only gates the start

   always_comb
   begin
      state_d        = state_q;
      trans_rx_req_o = 1'b0;
      accept         = 1'b0;
      case (state_q)
         trans_idle:
         begin
            // First beat opens the transaction in the buffer
            if (axi_r_valid_i && rx_data_gnt_i && start_ok)
            begin
               accept         = 1'b1;
               trans_rx_req_o = 1'b1;
               if (!axi_r_last_i) state_d = trans_run; // Single beat stays idle
            end
         end
         trans_run:
         begin
            if (axi_r_valid_i && rx_data_gnt_i)
            begin
               accept = 1'b1;
               if (axi_r_last_i) state_d = trans_idle; // Burst done
            end
         end
         default: state_d = trans_idle;
      endcase
   end

   // R ready follows the beat FIFO space
   assign axi_r_ready_o = accept;
   assign rx_data_req_o = accept;
   assign release_tid_o = accept & axi_r_last_i;   // ID back to the pool
   assign synch_req_o   = accept & axi_r_last_i;   // Completion pulse
   assign res_tid_o     = ext_tid_t'(axi_r_id_i);

endmodule

//--- ext_rx_properties.sv
// Concurrent handshake assertions for the AXI read interface, bound to ext_rx_if

`timescale 1ns/1ps

module ext_rx_properties (
   input logic                  clk_i,
   input logic                  rst_ni,
   input logic                  axi_r_valid_i,
   input logic                  axi_r_last_i,
   input mchan_rx_pkg::axi_id_t axi_r_id_i,
   input logic                  axi_r_ready_o,
   input logic                  trans_rx_req_o,
   input logic                  rx_data_req_o,
   input logic                  release_tid_o
);

   // A pending R beat stays offered with the same ID and last flag
   r_beat_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
      axi_r_valid_i && !axi_r_ready_o |=>
         axi_r_valid_i && $stable(axi_r_last_i) && $stable(axi_r_id_i))
      else $error("R beat withdrawn or changed before it was accepted");

   // No transaction opens in the middle of a burst
   no_start_mid_burst: assert property (@(posedge clk_i) disable iff (!rst_ni)
      rx_data_req_o && !axi_r_last_i |=> !trans_rx_req_o)
      else $error("New transaction opened while a burst was still running");

   // After an ID release the next accepted beat opens a transaction
   start_after_release: assert property (@(posedge clk_i) disable iff (!rst_ni)
      release_tid_o |=> (trans_rx_req_o == rx_data_req_o))
      else $error("First beat after a finished burst did not open a transaction");

endmodule

bind ext_rx_if ext_rx_properties i_rx_properties (
   .clk_i          (clk_i),
   .rst_ni         (rst_ni),
   .axi_r_valid_i  (axi_r_valid_i),
   .axi_r_last_i   (axi_r_last_i),
   .axi_r_id_i     (axi_r_id_i),
   .axi_r_ready_o  (axi_r_ready_o),
   .trans_rx_req_o (trans_rx_req_o),
   .rx_data_req_o  (rx_data_req_o),
   .release_tid_o  (release_tid_o)
);

//--- ext_rx_top.sv
// Top level of the external read path: command queue, ID pool, AXI interface, TCDM buffer

`timescale 1ns/1ps

module ext_rx_top #(
   parameter int unsigned NB_TID    = 4,
   parameter int unsigned CMD_DEPTH = 4
) (
   input  logic                     clk_i,
   input  logic                     rst_ni,
   // Command in
   input  mchan_rx_pkg::ext_add_t   cmd_add_i,
   input  mchan_rx_pkg::mchan_len_t cmd_len_i,
   input  logic                     cmd_bst_i,
   input  logic                     cmd_req_i,
   output logic                     cmd_gnt_o,
   // AXI AR
   output logic                     axi_ar_valid_o,
   output mchan_rx_pkg::axi_addr_t  axi_ar_addr_o,
   output mchan_rx_pkg::axi_len_t   axi_ar_len_o,
   output logic [2:0]               axi_ar_size_o,
   output logic [1:0]               axi_ar_burst_o,
   output mchan_rx_pkg::axi_id_t    axi_ar_id_o,
   input  logic                     axi_ar_ready_i,
   // AXI R
   input  logic                     axi_r_valid_i,
   input  mchan_rx_pkg::axi_data_t  axi_r_data_i,
   input  logic                     axi_r_last_i,
   input  mchan_rx_pkg::axi_id_t    axi_r_id_i,
   output logic                     axi_r_ready_o,
   // TCDM write
   output logic                     tcdm_req_o,
   output mchan_rx_pkg::tcdm_add_t  tcdm_add_o,
   output mchan_rx_pkg::axi_data_t  tcdm_data_o,
   input  logic                     tcdm_gnt_i,
   output logic                     synch_o
);
   import mchan_rx_pkg::*;

   logic       q_req, q_gnt, q_bst;           // Queue head handshake
   ext_add_t   q_add;
   mchan_len_t q_len;
   logic       valid_tid, release_tid;
   ext_tid_t   new_tid, res_tid, look_tid;
   ext_add_t   look_add;
   logic       trans_rx_req, trans_rx_gnt, rx_data_req, rx_data_gnt;

   ext_cmd_queue #(.DEPTH(CMD_DEPTH)) i_cmd_queue (
      .clk_i, .rst_ni,
      .push_add_i (cmd_add_i), .push_len_i (cmd_len_i), .push_bst_i (cmd_bst_i),
      .push_req_i (cmd_req_i), .push_gnt_o (cmd_gnt_o),
      .pop_req_o  (q_req),     .pop_gnt_i  (q_gnt),
      .pop_add_o  (q_add),     .pop_len_o  (q_len),     .pop_bst_o  (q_bst)
   );

   // Pop strobe doubles as the ID allocate
   ext_tid_gen #(.NB_TID(NB_TID)) i_tid_gen (
      .clk_i, .rst_ni,
      .alloc_i   (q_gnt),       .alloc_add_i   (q_add),
      .release_i (release_tid), .release_tid_i (res_tid),
      .look_tid_i (look_tid),   .valid_tid_o   (valid_tid),
      .new_tid_o (new_tid),     .look_add_o    (look_add)
   );

   ext_rx_if i_rx_if (
      .clk_i, .rst_ni,
      .cmd_add_i (q_add), .cmd_len_i (q_len), .cmd_bst_i (q_bst),
      .cmd_req_i (q_req), .cmd_gnt_o (q_gnt),
      .valid_tid_i (valid_tid), .new_tid_i (new_tid),
      .release_tid_o (release_tid), .res_tid_o (res_tid),
      .axi_ar_valid_o, .axi_ar_addr_o, .axi_ar_len_o, .axi_ar_size_o,
      .axi_ar_burst_o, .axi_ar_id_o, .axi_ar_ready_i,
      .axi_r_valid_i, .axi_r_last_i, .axi_r_id_i, .axi_r_ready_o,
      .trans_rx_gnt_i (trans_rx_gnt), .tcdm_gnt_i, .rx_data_gnt_i (rx_data_gnt),
      .trans_rx_req_o (trans_rx_req), .rx_data_req_o (rx_data_req),
      .synch_req_o (synch_o)
   );

   // R data and last go straight into the beat FIFO
   ext_rx_data_buffer #(.NB_TID(NB_TID)) i_data_buffer (
      .clk_i, .rst_ni,
      .trans_rx_req_i (trans_rx_req), .trans_tid_i (res_tid), .trans_rx_gnt_o (trans_rx_gnt),
      .rx_data_req_i (rx_data_req), .rx_data_dat_i (axi_r_data_i),
      .rx_data_last_i (axi_r_last_i), .rx_data_gnt_o (rx_data_gnt),
      .look_tid_o (look_tid), .look_add_i (look_add),
      .tcdm_req_o, .tcdm_add_o, .tcdm_data_o, .tcdm_gnt_i
   );

endmodule

//--- ext_tid_gen.sv
// Transaction ID free list with a per-ID base address table

`timescale 1ns/1ps

module ext_tid_gen #(
   parameter int unsigned NB_TID = 4
) (
   input  logic                   clk_i,
   input  logic                   rst_ni,
   input  logic                   alloc_i,
   input  mchan_rx_pkg::ext_add_t alloc_add_i,
   input  logic                   release_i,
   input  mchan_rx_pkg::ext_tid_t release_tid_i,
   input  mchan_rx_pkg::ext_tid_t look_tid_i,
   output logic                   valid_tid_o,
   output mchan_rx_pkg::ext_tid_t new_tid_o,
   output mchan_rx_pkg::ext_add_t look_add_o
);
   import mchan_rx_pkg::*;

   localparam int unsigned IDX_W = (NB_TID > 1) ? $clog2(NB_TID) : 1;

   logic [NB_TID-1:0] busy_q;             // One bit per ID in flight
   ext_add_t          add_tab [NB_TID];   // Command address per ID
   logic [IDX_W-1:0]  new_idx;
   logic              alloc;

   //**************************************************
   // Lowest free ID
   //**************************************************
   always_comb
   begin
      new_idx = '0;
      for (int i = NB_TID - 1; i >= 0; i--)
      begin
         if (!busy_q[i]) new_idx = IDX_W'(i); // Last hit wins, lowest index
      end
   end

   assign valid_tid_o = ~&busy_q;
   assign new_tid_o   = ext_tid_t'(new_idx);
   assign alloc       = alloc_i & valid_tid_o;

   // Busy bitmap, release and allocate never hit the same ID
   always_ff @(posedge clk_i, negedge rst_ni)
   begin
      if (!rst_ni)
         busy_q <= '0;                      // All IDs free
      else
      begin
         for (int i = 0; i < NB_TID; i++)
         begin
            if (release_i && release_tid_i == ext_tid_t'(i))
               busy_q[i] <= 1'b0;
            if (alloc && new_idx == IDX_W'(i))
               busy_q[i] <= 1'b1;
         end
      end
   end

   // Base address latched at allocation
   always_ff @(posedge clk_i)
   begin
      if (alloc) add_tab[new_idx] <= alloc_add_i;
   end

   assign look_add_o = add_tab[look_tid_i[IDX_W-1:0]]; // Combinational lookup

endmodule

//--- mchan_rx_pkg.sv
// Shared width typedefs and AXI burst constants for the external read path

package mchan_rx_pkg;

   //**************************************************
   // Command side widths
   //**************************************************
   typedef logic [28:0] ext_add_t;    // External byte address
   typedef logic [14:0] mchan_len_t;  // Length in bytes minus one
   typedef logic [3:0]  ext_tid_t;    // Transaction ID

   //**************************************************
   // AXI4 read channel widths
   //**************************************************
   typedef logic [31:0] axi_addr_t;
   typedef logic [63:0] axi_data_t;   // One 64-bit beat
   typedef logic [3:0]  axi_id_t;
   typedef logic [7:0]  axi_len_t;    // Beats minus one

   // Local memory word address
   typedef logic [15:0] tcdm_add_t;

   //**************************************************
   // Burst encodings and beat geometry
   //**************************************************
   localparam logic [1:0] BURST_FIXED = 2'b00;
   localparam logic [1:0] BURST_INCR  = 2'b01;

   // Bytes per beat, also the TCDM word size
   localparam int unsigned BEAT_BYTES = 8;

endpackage

//--- run.sh
#!/bin/sh
# Build and run the external read path testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_ext_rx -o sim_ext_rx
./obj_dir/sim_ext_rx > sim.log 2>&1 || echo "Simulator exited with an error status" >> sim.log
cat sim.log
if grep -q ">>> FAIL" sim.log || ! grep -q ">>> PASS" sim.log; then
   echo "Simulation failed"
   exit 1
fi
echo "Simulation passed"

//--- tb.f
mchan_rx_pkg.sv
ext_cmd_queue.sv
ext_tid_gen.sv
ext_rx_if.sv
ext_rx_data_buffer.sv
ext_rx_top.sv
ext_rx_properties.sv
tb_ext_rx.sv

//--- tb_ext_rx.sv
// Testbench for the external read path with random commands, AXI slave model and TCDM checker

`timescale 1ns/1ps

module tb_ext_rx;
   import mchan_rx_pkg::*;

   localparam int unsigned NB_TID    = 4;
   localparam int unsigned CMD_DEPTH = 4;
   localparam int unsigned RST_CYC   = 16;
   localparam int unsigned N_CMD     = 29;                        // Commands over all tests
   localparam int unsigned LIMIT     = N_CMD * 200 + 2 * RST_CYC; // Two resets

   logic       clk_i, rst_ni;
   ext_add_t   cmd_add_i;
   mchan_len_t cmd_len_i;
   logic       cmd_bst_i, cmd_req_i, cmd_gnt_o;
   logic       axi_ar_valid_o, axi_ar_ready_i;
   axi_addr_t  axi_ar_addr_o;
   axi_len_t   axi_ar_len_o;
   logic [2:0] axi_ar_size_o;
   logic [1:0] axi_ar_burst_o;
   axi_id_t    axi_ar_id_o, axi_r_id_i;
   logic       axi_r_valid_i, axi_r_last_i, axi_r_ready_o;
   axi_data_t  axi_r_data_i, tcdm_data_o;
   logic       tcdm_req_o, tcdm_gnt_i, synch_o;
   tcdm_add_t  tcdm_add_o;

   integer      seed = 83;
   integer      errors = 0, checks = 0, tests = 0, failed_tests = 0;
   integer      cycle = 0, synch_cnt = 0;
   integer      gnt_lvl = 128;        // tcdm_gnt_i high when a 7-bit draw is below this
   logic        r_fire = 1'b0;        // R handshake seen at the last rising edge
   logic [15:0] busy_ids = '0;        // IDs with an AR out and no last beat yet
   axi_len_t    beat = '0;            // Beat index inside the current burst
   axi_len_t    exp_len_q[$];         // Expected AR fields, in command order
   logic [1:0]  exp_bst_q[$];
   tcdm_add_t   exp_add_q[$];         // Expected TCDM writes, in order
   axi_data_t   exp_dat_q[$];
   axi_addr_t   ar_add_q[$];          // Accepted AR requests still owing beats
   axi_len_t    ar_len_q[$];
   axi_id_t     ar_id_q[$];

   ext_rx_top #(.NB_TID(NB_TID), .CMD_DEPTH(CMD_DEPTH)) UUT (.*);

   initial
   begin
      clk_i = 1'b0;
      forever #4 clk_i = ~clk_i;     // 8 ns period
   end

   // Beat payload is the word address in both halves, scrambled
   function automatic axi_data_t word_pattern(input logic [31:0] wa);
      return {wa, wa} ^ 64'h5A5A_C3C3_0F0F_9696;
   endfunction

   task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
      checks++;
      assert (got === exp) else
      begin
         $display("FAILED %s: got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   // Called on a falling edge, returns on a falling edge
   task automatic send_cmd(input ext_add_t add, input mchan_len_t len, input logic bst);
      integer      nb;
      logic [31:0] wa;
      cmd_add_i = add;
      cmd_len_i = len;
      cmd_bst_i = bst;
      cmd_req_i = 1'b1;
      // Beats spanned from the first to the last byte
      nb = ((int'(add) + int'(len)) >> 3) - (int'(add) >> 3) + 1;
      exp_len_q.push_back(axi_len_t'(nb - 1));
      exp_bst_q.push_back(bst ? BURST_INCR : BURST_FIXED);
      for (int i = 0; i < nb; i++)
      begin
         wa = 32'(add >> 3) + 32'(i);
         exp_add_q.push_back(wa[15:0]);
         exp_dat_q.push_back(word_pattern(wa));
      end
      do @(posedge clk_i); while (!cmd_gnt_o);
      @(negedge clk_i);
      cmd_req_i = 1'b0;
   endtask

   task automatic wait_done();
      while (exp_add_q.size() != 0 || ar_add_q.size() != 0) @(negedge clk_i);
      repeat (4) @(negedge clk_i);                // Room for a stray extra beat to show up
   endtask

   task automatic do_reset();
      cmd_req_i = 1'b0;
      rst_ni    = 1'b0;
      @(posedge clk_i);
      exp_len_q.delete();
      exp_bst_q.delete();
      exp_add_q.delete();
      exp_dat_q.delete();
      ar_add_q.delete();
      ar_len_q.delete();
      ar_id_q.delete();
      busy_ids = '0;
      repeat (RST_CYC) @(negedge clk_i);
      check_val("axi_ar_valid_o", 64'(axi_ar_valid_o), 64'(0));
      check_val("axi_r_ready_o", 64'(axi_r_ready_o), 64'(0));
      check_val("tcdm_req_o", 64'(tcdm_req_o), 64'(0));
      check_val("synch_o", 64'(synch_o), 64'(0));
      rst_ni = 1'b1;
   endtask

   task automatic end_test(input string name, input integer n_err);
      tests++;
      if (n_err != 0) failed_tests++;
      $display("Test %-15s %s (%0d errors)", name, (n_err == 0) ? "ok" : "failed", n_err);
   endtask

   //**************************************************
   // AXI R slave and grant drivers
   //**************************************************
   always @(negedge clk_i)
   begin
      logic [31:0] wa;
      tcdm_gnt_i     = ($random(seed) & 127) < gnt_lvl;
      axi_ar_ready_i = ($random(seed) & 3) != 0;     // AR slot free three times in four
      if (!rst_ni)
      begin
         axi_r_valid_i = 1'b0;
         r_fire        = 1'b0;
         beat          = '0;
      end
      else
      begin
         if (r_fire)
         begin
            r_fire        = 1'b0;
            axi_r_valid_i = 1'b0;
            if (beat == ar_len_q[0])
            begin
               void'(ar_add_q.pop_front());           // Burst complete
               void'(ar_len_q.pop_front());
               void'(ar_id_q.pop_front());
               beat = '0;
            end
            else
               beat++;
         end
         // Valid held until taken, random gaps between beats
         if (!axi_r_valid_i && ar_add_q.size() != 0 && ($random(seed) & 3) != 0)
         begin
            wa            = (ar_add_q[0] >> 3) + 32'(beat);
            axi_r_valid_i = 1'b1;
            axi_r_data_i  = word_pattern(wa);
            axi_r_last_i  = (beat == ar_len_q[0]);
            axi_r_id_i    = ar_id_q[0];
         end
      end
   end

   //**************************************************
   // Monitor and watchdog
   //**************************************************
   always @(posedge clk_i)
   begin
      cycle++;
      if (cycle > LIMIT)
      begin
         $display("Timeout after %0d cycles, the DUT stopped making progress", cycle);
         $display(">>> FAIL");
         $finish;
      end
      else if (rst_ni)
      begin
         if (axi_ar_valid_o && axi_ar_ready_i)
         begin
            checks++;
            assert (exp_len_q.size() != 0) else
            begin
               $display("AR request issued with no command pending");
               errors++;
            end
            if (exp_len_q.size() != 0)
            begin
               check_val("axi_ar_len_o", 64'(axi_ar_len_o), 64'(exp_len_q.pop_front()));
               check_val("axi_ar_burst_o", 64'(axi_ar_burst_o), 64'(exp_bst_q.pop_front()));
            end
            check_val("axi_ar_size_o", 64'(axi_ar_size_o), 64'(3));
            checks++;
            assert (!busy_ids[axi_ar_id_o] && $countones(busy_ids) < NB_TID) else
            begin
               $display("AR ID %h reused or more than %0d IDs in flight", axi_ar_id_o, NB_TID);
               errors++;
            end
            busy_ids[axi_ar_id_o] = 1'b1;
            ar_add_q.push_back(axi_ar_addr_o);
            ar_len_q.push_back(axi_ar_len_o);
            ar_id_q.push_back(axi_ar_id_o);
         end
         if (axi_r_valid_i && axi_r_ready_o) r_fire = 1'b1;
         if (synch_o)
         begin
            synch_cnt++;
            busy_ids[axi_r_id_i] = 1'b0;             // ID back in the pool
         end
         if (tcdm_req_o && tcdm_gnt_i)
         begin
            checks++;
            assert (exp_add_q.size() != 0) else
            begin
               $display("TCDM write to %h arrived with no beat expected", tcdm_add_o);
               errors++;
            end
            if (exp_add_q.size() != 0)
            begin
               check_val("tcdm_add_o", 64'(tcdm_add_o), 64'(exp_add_q.pop_front()));
               check_val("tcdm_data_o", tcdm_data_o, exp_dat_q.pop_front());
            end
         end
      end
   end

   //**************************************************
   // Test sequence
   //**************************************************
   initial
   begin
      integer   e0, e_rst, sync0;
      ext_add_t add;
      rst_ni         = 1'b0;
      cmd_req_i      = 1'b0;
      cmd_add_i      = '0;
      cmd_len_i      = '0;
      cmd_bst_i      = 1'b0;
      axi_ar_ready_i = 1'b0;
      axi_r_valid_i  = 1'b0;
      axi_r_data_i   = '0;
      axi_r_last_i   = 1'b0;
      axi_r_id_i     = '0;
      tcdm_gnt_i     = 1'b0;
      @(negedge clk_i);
      do_reset();
      e_rst = errors;

      e0 = errors;                                    // Single aligned commands
      for (int i = 0; i < 6; i++)
      begin
         add      = ext_add_t'($random(seed));
         add[2:0] = 3'b000;
         send_cmd(add, mchan_len_t'($random(seed) & 127), 1'($random(seed)));
         wait_done();
      end
      end_test("burst length", errors - e0);

      e0 = errors;
      for (int i = 0; i < 6; i++)
         send_cmd(ext_add_t'($random(seed)), mchan_len_t'($random(seed) & 127), 1'b1);
      wait_done();
      end_test("write sequence", errors - e0);

      e0      = errors;
      gnt_lvl = 64;                                   // Grant about half the time
      for (int i = 0; i < 6; i++)
         send_cmd(ext_add_t'($random(seed)), mchan_len_t'($random(seed) & 127), 1'b1);
      wait_done();
      gnt_lvl = 128;
      end_test("back-pressure", errors - e0);

      e0    = errors;
      sync0 = synch_cnt;
      for (int i = 0; i < 8; i++)
         send_cmd(ext_add_t'($random(seed)), mchan_len_t'($random(seed) & 63), 1'b1);
      wait_done();
      check_val("synch_o count", 64'(synch_cnt - sync0), 64'(8));
      end_test("ID reuse", errors - e0);

      e0 = errors;                                    // Reset with bursts in flight
      send_cmd(ext_add_t'($random(seed)), mchan_len_t'(127), 1'b1);
      send_cmd(ext_add_t'($random(seed)), mchan_len_t'(127), 1'b1);
      repeat (5) @(negedge clk_i);
      do_reset();
      send_cmd(ext_add_t'($random(seed)), mchan_len_t'($random(seed) & 127), 1'b1);
      wait_done();
      end_test("reset state", errors - e0 + e_rst);

      $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
               tests, failed_tests, checks, errors);
      if (errors == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule
